//--- all.f
logic/apu_reg_pkg.sv
logic/apu_audio_pkg.sv
logic/sq_chan_if.sv
logic/apu_timebase.sv
logic/apu_bus_decoder.sv
logic/square_channel.sv
logic/apu_mixer.sv
logic/apu_square_top.sv
testbench/apu_square_assert.sv
testbench/apu_square_tb.sv

//--- testbench/apu_square_tb.sv
`timescale 1ns/1ps
`default_nettype none

module apu_square_tb import apu_reg_pkg::*, apu_audio_pkg::*; ();

	localparam int NUM_CH     = 2;
	localparam int FREQ_DIV   = 2;
	localparam int LEN_DIV    = 64;
	localparam int CLK_PERIOD = 4;
	localparam int WAVE_MAX   = 8 * 16 * FREQ_DIV;   // longest period when freq_lo >= 0xF0

	typedef enum {OP_WR, OP_RD, OP_MIX, OP_WAVE, OP_LEN, OP_REACH} op_t;

	typedef struct {
		op_t        op;
		logic [7:0] addr;
		logic [7:0] data;
		int         exp;
	} step_t;

	logic              clk;
	logic              rst_n;
	logic [ADDR_W-1:0] addr;
	logic [7:0]        wdata;
	logic              wr;
	logic              rd;
	logic [7:0]        rdata;
	logic [MIX_W-1:0]  mix;

	step_t  steps [$];
	int     budget = 0;                   // watchdog length in clocks
	logic   armed = 1'b0;
	integer seed = 32'h4d77_5783;
	logic [1:0]  duty0;                   // channel 0 as last written
	logic [10:0] freq0;

	apu_square_top #(
		.NUM_CH   (NUM_CH),
		.FREQ_DIV (FREQ_DIV),
		.LEN_DIV  (LEN_DIV)
	) u_apu_square_top (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (addr),
		.wdata (wdata),
		.wr    (wr),
		.rd    (rd),
		.rdata (rdata),
		.mix   (mix)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		wait (armed);
		#(budget * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d clocks", budget);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		wait (u_apu_square_top.u_assert.fail_count != 0);
		abort_run("bound assertion failed");
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at %0t ns: %s", $time, why);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic void add_step(op_t op, logic [7:0] a, logic [7:0] d, int exp);
		steps.push_back('{op, a, d, exp});
		case (op)
			OP_WAVE:  budget += 4 * WAVE_MAX;
			OP_REACH: budget += 2 * WAVE_MAX;
			OP_LEN:   budget += (exp + 2) * LEN_DIV;
			default:  budget += 2;
		endcase
	endfunction

	function automatic int duty_eighths(input logic [1:0] code);
		case (code)
			2'd0:    return 1;                // 12.5 %
			2'd1:    return 2;
			2'd2:    return 4;
			default: return 6;                // 75 %
		endcase
	endfunction

	function automatic logic [7:0] status_exp(input logic [1:0] act);
		return {6'h3F, act};                  // unused flags read 1
	endfunction

	// every bus task starts and ends 1 ns after a rising edge
	task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		rd    = 1'b0;
		@(posedge clk);
		#1;
		wr = 1'b0;
		case (a)
			CH_BASE + 8'(REG_NR1): duty0 = d[7:6];
			CH_BASE + 8'(REG_NR3): freq0[7:0] = d;
			CH_BASE + 8'(REG_NR4): freq0[10:8] = d[2:0];
			default: ;
		endcase
	endtask

	task automatic bus_read(input logic [7:0] a, output logic [7:0] got);
		addr = a;
		rd   = 1'b1;
		wr   = 1'b0;
		@(negedge clk);
		got = rdata;
		@(posedge clk);
		#1;
		rd = 1'b0;
	endtask

	task automatic next_mix(output int m);
		@(posedge clk);
		#1;
		m = mix;
	endtask

	// rise, fall, rise first so the truncated step after a trigger is skipped
	task automatic measure_wave(input int level);
		int step_clk;
		int high;
		int low;
		int m;
		step_clk = (2048 - freq0) * FREQ_DIV;
		m = mix;
		while (m == 0) next_mix(m);
		while (m != 0) next_mix(m);
		while (m == 0) next_mix(m);
		check_value("mix level", m, level);
		high = 0;
		low  = 0;
		while (m != 0) begin
			high++;
			next_mix(m);
		end
		while (m == 0) begin
			low++;
			next_mix(m);
		end
		check_value("mix high clocks", high, duty_eighths(duty0) * step_clk);
		check_value("mix period clocks", high + low, 8 * step_clk);
	endtask

	task automatic wait_len(input logic [7:0] flag, input int ticks);
		logic [7:0] st;
		int t;
		t = 0;
		bus_read(STATUS_ADDR, st);
		while ((st & flag) != 0) begin
			t++;
			bus_read(STATUS_ADDR, st);
		end
		check_value("length ticks", (t + LEN_DIV - 1) / LEN_DIV, ticks);
	endtask

	task automatic wait_mix(input int target);
		int m;
		int n;
		m = mix;
		n = 0;
		while (m != target) begin
			if (n == 2 * WAVE_MAX) begin
				abort_run($sformatf("mix did not reach %0d within two periods", target));
			end else begin
				next_mix(m);
				n++;
			end
		end
	endtask

	task automatic build_table();
		logic [7:0] mask [4];
		logic [7:0] base;
		logic [7:0] val;
		logic [7:0] flo;
		logic [3:0] vol;
		mask = '{RD_MASK_NR1, 8'h00, RD_MASK_NR3, RD_MASK_NR4};
		add_step(OP_MIX, 0, 0, 0);                          // reset state
		add_step(OP_RD, STATUS_ADDR, 0, status_exp(2'b00));
		for (int c = 0; c < NUM_CH; c++) begin
			base = CH_BASE + 8'(CH_SPAN * c);
			for (int r = 1; r <= 4; r++) add_step(OP_RD, base + r, 0, mask[r-1]);
		end
		for (int c = 0; c < NUM_CH; c++) begin           // readback masks
			base = CH_BASE + 8'(CH_SPAN * c);
			add_step(OP_RD, base, 0, 8'hFF);
			for (int v = 0; v < 2; v++) begin
				val = v ? 8'h00 : 8'hFF;
				for (int r = 1; r <= 4; r++) begin
					add_step(OP_WR, base + r, val, 0);
					add_step(OP_RD, base + r, 0, val | mask[r-1]);
				end
			end
		end
		add_step(OP_RD, 8'h1A, 0, 8'hFF);
		add_step(OP_RD, 8'h00, 0, 8'hFF);
		add_step(OP_RD, 8'h27, 0, 8'hFF);
		add_step(OP_WR, 8'h17, 8'h00, 0);                    // ch1 dac off
		add_step(OP_WR, 8'h19, 8'h80, 0);
		add_step(OP_RD, STATUS_ADDR, 0, status_exp(2'b00));
		add_step(OP_WR, 8'h12, 8'hF0, 0);
		add_step(OP_WR, 8'h14, 8'h87, 0);
		add_step(OP_RD, STATUS_ADDR, 0, status_exp(2'b01));
		for (int d = 0; d < 4; d++) begin                // one waveform per duty
			flo = 8'hF0 | 8'($random(seed) & 32'hF);
			vol = 4'(4 * d + 3);
			add_step(OP_WR, 8'h12, {vol, 4'h0}, 0);
			add_step(OP_WR, 8'h11, {2'(d), 6'h00}, 0);
			add_step(OP_WR, 8'h13, flo, 0);
			add_step(OP_WR, 8'h14, 8'h87, 0);
			add_step(OP_WAVE, 0, 0, vol);
		end
		add_step(OP_WR, 8'h11, 8'hBA, 0);                    // length field 0x3A
		add_step(OP_WR, 8'h14, 8'hC7, 0);
		add_step(OP_LEN, 0, 8'h01, LEN_MAX - 'h3A);
		add_step(OP_MIX, 0, 0, 0);
		flo = 8'hF0 | 8'($random(seed) & 32'hF);
		add_step(OP_WR, 8'h11, 8'h80, 0);                    // both at 50 %
		add_step(OP_WR, 8'h12, 8'h90, 0);
		add_step(OP_WR, 8'h13, flo, 0);
		add_step(OP_WR, 8'h16, 8'h80, 0);
		add_step(OP_WR, 8'h17, 8'h50, 0);
		add_step(OP_WR, 8'h18, flo, 0);
		add_step(OP_WR, 8'h14, 8'h87, 0);
		add_step(OP_WR, 8'h19, 8'h87, 0);
		add_step(OP_REACH, 0, 0, 9 + 5);
		add_step(OP_RD, STATUS_ADDR, 0, status_exp(2'b11));
	endtask

	initial begin
		logic [7:0] got;
		addr  = '0;
		wdata = '0;
		wr    = 1'b0;
		rd    = 1'b0;
		rst_n = 1'b1;
		duty0 = '0;
		freq0 = '0;
		build_table();
		budget += 100;                        // reset and margin
		armed = 1'b1;
		#1;
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (steps[i]) begin
			case (steps[i].op)
				OP_WR:    bus_write(steps[i].addr, steps[i].data);
				OP_RD: begin
					bus_read(steps[i].addr, got);
					check_value($sformatf("rdata @0x%02h", steps[i].addr), got, steps[i].exp);
				end
				OP_MIX:   check_value("mix", mix, steps[i].exp);
				OP_WAVE:  measure_wave(steps[i].exp);
				OP_LEN:   wait_len(steps[i].data, steps[i].exp);
				default:  wait_mix(steps[i].exp);
			endcase
		end
		if (u_apu_square_top.u_assert.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("%0d assertion failures", u_apu_square_top.u_assert.fail_count);
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/apu_square_assert.sv
`timescale 1ns/1ps
`default_nettype none

module apu_square_assert import apu_audio_pkg::*; #(
	parameter int NUM_CH = 2
) (
	input logic             clk,
	input logic             rst_n,
	input logic             rd,
	input logic [7:0]       rdata,
	input logic [MIX_W-1:0] mix
);

	int fail_count = 0;   // read by the testbench

	a_rdata_idle: assert property (@(posedge clk) !rd |-> rdata == 8'hFF)
		else begin
			$error("rdata not 0xFF while rd is low");
			fail_count++;
		end

	a_mix_reset: assert property (@(posedge clk) !rst_n |-> mix == '0)
		else begin
			$error("mix not 0 during reset");
			fail_count++;
		end

	// each channel adds at most 15
	a_mix_max: assert property (@(posedge clk) disable iff (!rst_n) mix <= 15 * NUM_CH)
		else begin
			$error("mix above full scale");
			fail_count++;
		end

endmodule

bind apu_square_top apu_square_assert #(
	.NUM_CH (NUM_CH)
) u_assert (
	.clk   (clk),
	.rst_n (rst_n),
	.rd    (rd),
	.rdata (rdata),
	.mix   (mix)
);

`default_nettype wire

//--- logic/apu_square_top.sv
`timescale 1ns/1ps
`default_nettype none

module apu_square_top import apu_reg_pkg::*, apu_audio_pkg::*; #(
	parameter int NUM_CH   = 2,
	parameter int FREQ_DIV = 2,
	parameter int LEN_DIV  = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic [7:0]        wdata,
	input  logic              wr,
	input  logic              rd,
	output logic [7:0]        rdata,
	output logic [MIX_W-1:0]  mix
);

	logic freq_tick;
	logic len_tick;

	sq_chan_if chan_if [NUM_CH] ();

	apu_timebase #(
		.FREQ_DIV (FREQ_DIV),
		.LEN_DIV  (LEN_DIV)
	) u_timebase (
		.clk       (clk),
		.rst_n     (rst_n),
		.freq_tick (freq_tick),
		.len_tick  (len_tick)
	);

	apu_bus_decoder #(
		.NUM_CH (NUM_CH)
	) u_decoder (
		.addr  (addr),
		.wdata (wdata),
		.wr    (wr),
		.rd    (rd),
		.rdata (rdata),
		.ch    (chan_if)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_chan
		square_channel u_chan (
			.clk       (clk),
			.rst_n     (rst_n),
			.freq_tick (freq_tick),
			.len_tick  (len_tick),
			.bus       (chan_if[i])
		);
	end

	apu_mixer #(
		.NUM_CH (NUM_CH)
	) u_mixer (
		.clk   (clk),
		.rst_n (rst_n),
		.ch    (chan_if),
		.mix   (mix)
	);

endmodule

`default_nettype wire

//--- logic/apu_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module apu_mixer import apu_audio_pkg::*; #(
	parameter int NUM_CH = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	sq_chan_if.mix           ch [NUM_CH],
	output logic [MIX_W-1:0] mix
);

	sample_t          samples [NUM_CH];
	logic [MIX_W-1:0] sum;

	for (genvar i = 0; i < NUM_CH; i++) begin : g_tap
		assign samples[i] = ch[i].sample;
	end

	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			sum = sum + MIX_W'(samples[i]);
		end
	end

	// one clock behind the channel samples
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mix <= '0;
		end else begin
			mix <= sum;
		end
	end

endmodule

`default_nettype wire

//--- logic/square_channel.sv
`timescale 1ns/1ps
`default_nettype none

module square_channel import apu_reg_pkg::*, apu_audio_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   freq_tick,
	input  logic   len_tick,
	sq_chan_if.chan bus
);

	// register fields
	logic [1:0]       duty;          // NRx1[7:6]
	logic [LEN_W-1:0] len_load;      // NRx1[5:0]
	logic [7:0]       nr2;           // volume[7:4], env bits kept for readback
	logic [7:0]       freq_lo;       // NRx3
	logic [2:0]       freq_hi;       // NRx4[2:0]
	logic             len_en;        // NRx4[6]

	logic wr_nr1;
	logic wr_nr2;
	logic wr_nr3;
	logic wr_nr4;
	logic trigger;
	logic dac_on;

	freq_t            freq;
	freq_t            freq_cnt;
	logic [2:0]       duty_pos;
	logic [LEN_W-1:0] len_cnt;
	logic             active;

	assign wr_nr1  = bus.reg_wr && (bus.reg_sel == SEL_NR1);
	assign wr_nr2  = bus.reg_wr && (bus.reg_sel == SEL_NR2);
	assign wr_nr3  = bus.reg_wr && (bus.reg_sel == SEL_NR3);
	assign wr_nr4  = bus.reg_wr && (bus.reg_sel == SEL_NR4);
	assign trigger = wr_nr4 && bus.wdata[7];
	assign dac_on  = |nr2[7:3];
	assign freq    = {freq_hi, freq_lo};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			duty     <= '0;
			len_load <= '0;
			nr2      <= '0;
			freq_lo  <= '0;
			freq_hi  <= '0;
			len_en   <= 1'b0;
		end else begin
			if (wr_nr1) begin
				duty     <= bus.wdata[7:6];
				len_load <= bus.wdata[LEN_W-1:0];
			end
			if (wr_nr2) begin
				nr2 <= bus.wdata;
			end
			if (wr_nr3) begin
				freq_lo <= bus.wdata;
			end
			if (wr_nr4) begin
				len_en  <= bus.wdata[6];
				freq_hi <= bus.wdata[2:0];   // trigger bit is not stored
			end
		end
	end

	// frequency timer and duty sequencer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			freq_cnt <= '0;
			duty_pos <= '0;
		end else if (trigger) begin
			freq_cnt <= {bus.wdata[2:0], freq_lo};   // new high bits apply at once
			duty_pos <= '0;
		end else if (freq_tick) begin
			if (freq_cnt == FREQ_LAST) begin
				freq_cnt <= freq;
				duty_pos <= duty_pos + 3'd1;
			end else begin
				freq_cnt <= freq_cnt + 1'b1;
			end
		end
	end

	// length counter and active flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			len_cnt <= '0;
			active  <= 1'b0;
		end else if (trigger) begin
			len_cnt <= len_load;
			active  <= dac_on;                       // dac off keeps it silent
		end else begin
			if (wr_nr1) begin
				len_cnt <= bus.wdata[LEN_W-1:0];
			end else if (len_en && len_tick) begin
				if (len_cnt == LEN_LAST) begin
					active <= 1'b0;                  // tick that reaches LEN_MAX
				end else begin
					len_cnt <= len_cnt + 1'b1;
				end
			end
			if (wr_nr2 && (bus.wdata[7:3] == 5'd0)) begin
				active <= 1'b0;
			end
		end
	end

	always_comb begin
		case (bus.reg_sel)
			SEL_NR1: bus.rdata_ch = {duty, len_load} | RD_MASK_NR1;
			SEL_NR2: bus.rdata_ch = nr2;
			SEL_NR3: bus.rdata_ch = freq_lo | RD_MASK_NR3;
			default: bus.rdata_ch = {1'b0, len_en, 3'b000, freq_hi} | RD_MASK_NR4;
		endcase
	end

	assign bus.active = active;
	assign bus.sample = (active && DUTY_TABLE[duty][duty_pos]) ? sample_t'(nr2[7:4]) : '0;

endmodule

`default_nettype wire

//--- logic/apu_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apu_bus_decoder import apu_reg_pkg::*, apu_audio_pkg::*; #(
	parameter int NUM_CH = 2
) (
	input  logic [ADDR_W-1:0] addr,
	input  logic [7:0]        wdata,
	input  logic              wr,
	input  logic              rd,
	output logic [7:0]        rdata,
	sq_chan_if.bus            ch [NUM_CH]
);

	logic [NUM_CH-1:0] hit;                  // addr falls in NRx1..NRx4 of channel i
	logic [NUM_CH-1:0] ch_active;
	logic [7:0]        ch_rdata [NUM_CH];
	logic [7:0]        status;

	if (NUM_CH < 1 || NUM_CH > MAX_CH) begin : g_bad_num_ch
		$error("apu_bus_decoder: NUM_CH must be 1 to %0d", MAX_CH);
	end

	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		localparam logic [ADDR_W-1:0] BASE = CH_BASE + ADDR_W'(CH_SPAN * i);

		logic [ADDR_W-1:0] offs;
		logic [ADDR_W-1:0] idx;

		assign offs = addr - BASE;               // wraps high below BASE
		assign idx  = offs - ADDR_W'(REG_NR1);

		assign hit[i] = (offs >= ADDR_W'(REG_NR1)) && (offs <= ADDR_W'(REG_NR4));

		assign ch[i].reg_wr  = wr && hit[i];
		assign ch[i].reg_sel = reg_sel_t'(idx[1:0]);
		assign ch[i].wdata   = wdata;

		assign ch_rdata[i]  = ch[i].rdata_ch;
		assign ch_active[i] = ch[i].active;
	end

	// unused status bits read as 1
	always_comb begin
		status = 8'hFF;
		status[NUM_CH-1:0] = ch_active;
	end

	always_comb begin
		rdata = 8'hFF;                           // idle bus, offset 0, unmapped
		if (rd) begin
			if (addr == STATUS_ADDR) begin
				rdata = status;
			end
			for (int i = 0; i < NUM_CH; i++) begin
				if (hit[i]) begin
					rdata = ch_rdata[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/apu_timebase.sv
`timescale 1ns/1ps
`default_nettype none

module apu_timebase #(
	parameter int FREQ_DIV = 2,
	parameter int LEN_DIV  = 64
) (
	input  logic clk,
	input  logic rst_n,
	output logic freq_tick,
	output logic len_tick
);

	localparam int DIV [2] = '{FREQ_DIV, LEN_DIV};

	// divider 0 feeds the frequency timers, divider 1 the length counters
	for (genvar i = 0; i < 2; i++) begin : g_div
		localparam int W = (DIV[i] > 1) ? $clog2(DIV[i]) : 1;
		localparam logic [W-1:0] LAST = W'(DIV[i] - 1);

		logic [W-1:0] cnt;
		logic         tick;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt  <= '0;
				tick <= 1'b0;
			end else if (cnt == LAST) begin
				cnt  <= '0;
				tick <= 1'b1;     // one pulse per period
			end else begin
				cnt  <= cnt + 1'b1;
				tick <= 1'b0;
			end
		end
	end

	assign freq_tick = g_div[0].tick;
	assign len_tick  = g_div[1].tick;

endmodule

`default_nettype wire

//--- logic/sq_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

// one per square channel, shared by decoder, channel and mixer
interface sq_chan_if import apu_reg_pkg::*, apu_audio_pkg::*; ();

	logic       reg_wr;     // one cycle write strobe
	reg_sel_t   reg_sel;    // which NRx register
	logic [7:0] wdata;
	logic [7:0] rdata_ch;   // masked readback of reg_sel
	logic       active;
	sample_t    sample;

	modport bus (
		output reg_wr,
		output reg_sel,
		output wdata,
		input  rdata_ch,
		input  active
	);

	modport chan (
		input  reg_wr,
		input  reg_sel,
		input  wdata,
		output rdata_ch,
		output active,
		output sample
	);

	modport mix (
		input  sample
	);

endinterface

`default_nettype wire

//--- logic/apu_audio_pkg.sv
`default_nettype none

package apu_audio_pkg;

	localparam int MAX_CH = 4;                            // square channels supported

	localparam int SAMPLE_W = 4;                          // per channel sample
	localparam int MIX_W = 6;                             // 4 x 15 fits

	typedef logic [SAMPLE_W-1:0] sample_t;

	// frequency timer
	localparam int FREQ_W = 11;
	typedef logic [FREQ_W-1:0] freq_t;
	localparam freq_t FREQ_LAST = '1;                     // wraps after 2047

	// length counter
	localparam int LEN_W = 6;                             // NRx1 length field
	localparam int LEN_MAX = 64;
	localparam logic [LEN_W-1:0] LEN_LAST = LEN_W'(LEN_MAX - 1);

	// duty waveforms, indexed by NRx1[7:6], one bit per step
	localparam logic [7:0] DUTY_TABLE [4] = '{
		8'b0000_0001,                                     // 12.5 %
		8'b1000_0001,                                     // 25 %
		8'b1000_0111,                                     // 50 %
		8'b0111_1110                                      // 75 %
	};

endpackage

`default_nettype wire

//--- logic/apu_reg_pkg.sv
`default_nettype none

package apu_reg_pkg;

	localparam int ADDR_W = 8;                            // cpu byte bus address

	localparam logic [ADDR_W-1:0] CH_BASE = 8'h10;        // channel 0 block
	localparam int CH_SPAN = 5;                           // addresses per channel

	// offsets inside a channel block, offset 0 is the unused sweep slot
	localparam int REG_NR1 = 1;                           // duty, length
	localparam int REG_NR2 = 2;                           // volume, dac
	localparam int REG_NR3 = 3;                           // freq low
	localparam int REG_NR4 = 4;                           // trigger, len enable, freq high

	localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'h26;    // active flags

	// bits that read back as 1
	localparam logic [7:0] RD_MASK_NR1 = 8'h3F;           // only duty readable
	localparam logic [7:0] RD_MASK_NR3 = 8'hFF;           // write only
	localparam logic [7:0] RD_MASK_NR4 = 8'hBF;           // only length enable readable

	typedef enum logic [1:0] {
		SEL_NR1 = 2'(REG_NR1 - 1),
		SEL_NR2 = 2'(REG_NR2 - 1),
		SEL_NR3 = 2'(REG_NR3 - 1),
		SEL_NR4 = 2'(REG_NR4 - 1)
	} reg_sel_t;

endpackage

`default_nettype wire
